// File: project.f
+incdir+design
design/rename_pkg.sv
design/rn_skid_buffer.sv
design/rn_map_table.sv
design/rn_rename_stage.sv
design/rn_output_reg.sv
design/rename_top.sv
verification/rename_tb.sv

// File: verification/rename_tb.sv
`include "rename_params.svh"

module rename_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import rename_pkg::*;

    logic                 cpu_clock = 1'b0;
    logic                 rst_n;
    logic                 flush;
    logic                 valid;
    rn_bundle_t           bundle;
    logic                 rn_busy;
    logic                 out_valid;
    renamed_bundle_t      out_bundle;
    logic                 busy;
    logic [`RN_WIDTH-1:0] fl_rd;
    phys_reg_t            fl_data [`RN_WIDTH];
    logic [`RN_WIDTH-1:0] fl_empty;
    commit_t              commit [`RN_WIDTH];

    // Free list hands out 32 upward; port 1 always shows the entry after port 0.
    logic [4:0]      fl_cnt;
    logic [1:0]      fl_step;
    int              pop_count;

    phys_reg_t       spec_map   [`RN_ARCH_REGS];
    phys_reg_t       commit_map [`RN_ARCH_REGS];
    logic [4:0]      model_cnt;
    int              exp_pops;
    renamed_bundle_t exp_q [$];
    renamed_bundle_t last_out;
    string           test_name;

    always #50 cpu_clock = ~cpu_clock;

    rename_top u_dut (
        .cpu_clock_i  (cpu_clock),
        .rst_n_i      (rst_n),
        .flush_i      (flush),
        .valid_i      (valid),
        .bundle_i     (bundle),
        .rn_busy_o    (rn_busy),
        .out_valid_o  (out_valid),
        .out_bundle_o (out_bundle),
        .busy_i       (busy),
        .fl_rd_o      (fl_rd),
        .fl_data_i    (fl_data),
        .fl_empty_i   (fl_empty),
        .commit_i     (commit)
    );

    assign fl_data[0] = {1'b1, fl_cnt};
    assign fl_data[1] = {1'b1, fl_cnt + 5'd1};

    always @(posedge cpu_clock) begin
        if (!rst_n) begin
            fl_cnt <= '0;
        end else begin
            fl_cnt <= fl_cnt + fl_step;
        end
    end

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("error %s %s expected %h actual %h", test_name, what, expected, actual);
            $display("Something failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s: %s", test_name, reason);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    // Outputs and pops are sampled away from the clock edge.
    always @(negedge cpu_clock) begin
        if (rst_n) begin
            fl_step = fl_rd[1] ? 2'd2 : {1'b0, fl_rd[0]};
            pop_count += int'(fl_rd[0]) + int'(fl_rd[1]);
            if (out_valid && !busy) begin
                if (exp_q.size() == 0) begin
                    fail_run("an output packet appeared with none expected");
                end else begin
                    last_out = out_bundle;
                    check_value("packet", exp_q.pop_front(), out_bundle);
                end
            end
        end
    end

    function automatic arch_reg_t random_reg();
        return arch_reg_t'($urandom_range(0, 31));
    endfunction

    function automatic rn_slot_t make_slot(input arch_reg_t rs1, input arch_reg_t rs2,
                                           input arch_reg_t dest, input logic writes);
        rn_slot_t s;
        s.valid       = 1'b1;
        s.port        = rn_port_e'($urandom_range(0, 1));
        s.rs1         = rs1;
        s.rs2         = rs2;
        s.dest        = dest;
        s.writes_dest = writes;
        return s;
    endfunction

    function automatic rn_bundle_t random_bundle();
        rn_bundle_t b;
        b.slot0 = make_slot(random_reg(), random_reg(), random_reg(), $urandom_range(0, 3) != 0);
        b.slot1 = make_slot(random_reg(), random_reg(), random_reg(), $urandom_range(0, 3) != 0);
        return b;
    endfunction

    // Reference rename of one accepted bundle.
    task automatic predict_bundle(input rn_bundle_t b);
        renamed_bundle_t r;
        logic [1:0]      alloc;
        phys_reg_t       n0;
        phys_reg_t       n1;
        alloc[0] = b.slot0.valid && b.slot0.writes_dest && (b.slot0.dest != 0);
        alloc[1] = b.slot1.valid && b.slot1.writes_dest && (b.slot1.dest != 0);
        n0 = alloc[0] ? {1'b1, model_cnt} : '0;
        n1 = alloc[1] ? {1'b1, model_cnt + 5'd1} : '0;
        r.slot0.valid     = b.slot0.valid;
        r.slot0.port      = b.slot0.port;
        r.slot0.prs1      = spec_map[b.slot0.rs1];
        r.slot0.prs2      = spec_map[b.slot0.rs2];
        r.slot0.arch_dest = b.slot0.dest;
        r.slot0.allocated = alloc[0];
        r.slot0.old_preg  = spec_map[b.slot0.dest];
        r.slot0.new_preg  = n0;
        r.slot1.valid     = b.slot1.valid;
        r.slot1.port      = b.slot1.port;
        r.slot1.prs1      = (alloc[0] && b.slot1.rs1 == b.slot0.dest) ? n0 : spec_map[b.slot1.rs1];
        r.slot1.prs2      = (alloc[0] && b.slot1.rs2 == b.slot0.dest) ? n0 : spec_map[b.slot1.rs2];
        r.slot1.arch_dest = b.slot1.dest;
        r.slot1.allocated = alloc[1];
        r.slot1.old_preg  = (alloc[0] && b.slot1.dest == b.slot0.dest) ? n0
                                                                         : spec_map[b.slot1.dest];
        r.slot1.new_preg  = n1;
        if (alloc[0]) begin
            spec_map[b.slot0.dest] = n0;
        end
        if (alloc[1]) begin
            spec_map[b.slot1.dest] = n1;
        end
        model_cnt = model_cnt + (alloc[1] ? 5'd2 : {4'd0, alloc[0]});
        exp_pops += int'(alloc[0]) + int'(alloc[1]);
        exp_q.push_back(r);
    endtask

    // Drive a bundle for one cycle; taken tells whether the next edge accepts it.
    task automatic offer_bundle(input rn_bundle_t b, output logic taken);
        @(posedge cpu_clock);
        valid  <= 1'b1;
        bundle <= b;
        @(negedge cpu_clock);
        taken = !rn_busy;
        if (taken) begin
            predict_bundle(b);
        end
    endtask

    task automatic send_bundle(input rn_bundle_t b);
        logic taken;
        int   tries;
        taken = 1'b0;
        tries = 0;
        while (!taken) begin
            offer_bundle(b, taken);
            tries++;
            if (!taken && tries > 50) begin
                fail_run("input stayed busy and the bundle was never accepted");
            end
        end
    endtask

    task automatic stop_input();
        @(posedge cpu_clock);
        valid <= 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge cpu_clock);
            cycles++;
            if (cycles > 100) begin
                fail_run("expected packets never came out");
            end
        end
        check_value("pop count", exp_pops, pop_count);
    endtask

    task automatic wait_out_valid();
        int cycles;
        cycles = 0;
        @(negedge cpu_clock);
        while (!out_valid) begin
            @(negedge cpu_clock);
            cycles++;
            if (cycles > 50) begin
                fail_run("out_valid_o never rose");
            end
        end
    endtask

    task automatic test_first_bundle();
        rn_bundle_t b;
        test_name = "first_bundle";
        @(negedge cpu_clock);
        check_value("out_valid after reset", 0, out_valid);
        check_value("rn_busy after reset", 0, rn_busy);
        check_value("fl_rd after reset", 0, fl_rd);
        b.slot0 = make_slot(5'd1, 5'd2, 5'd3, 1'b1);
        b.slot1 = make_slot(5'd4, 5'd5, 5'd6, 1'b1);
        send_bundle(b);
        stop_input();
        wait_drain();
        check_value("slot0 prs1", 1, last_out.slot0.prs1);
        check_value("slot1 prs2", 5, last_out.slot1.prs2);
        check_value("slot0 new_preg", 32, last_out.slot0.new_preg);
        check_value("slot1 new_preg", 33, last_out.slot1.new_preg);
        check_value("slot1 old_preg", 6, last_out.slot1.old_preg);
    endtask

    task automatic test_bundle_bypass();
        rn_bundle_t b;
        arch_reg_t  d;
        phys_reg_t  first_free;
        int         pops_before;
        test_name = "bundle_bypass";
        d = arch_reg_t'($urandom_range(1, 31));
        // Slot0 takes the next entry of the free list.
        first_free = {1'b1, model_cnt};
        b.slot0 = make_slot(random_reg(), random_reg(), d, 1'b1);
        b.slot1 = make_slot(d, random_reg(), d, 1'b1);
        send_bundle(b);
        stop_input();
        wait_drain();
        check_value("slot0 new_preg", first_free, last_out.slot0.new_preg);
        check_value("slot1 prs1 bypass", first_free, last_out.slot1.prs1);
        check_value("slot1 old_preg bypass", first_free, last_out.slot1.old_preg);
        pops_before = pop_count;
        b.slot0 = make_slot(random_reg(), random_reg(), 5'd0, 1'b1);
        b.slot1 = make_slot(random_reg(), random_reg(), 5'd0, 1'b1);
        send_bundle(b);
        stop_input();
        wait_drain();
        check_value("r0 allocated", 0, {last_out.slot0.allocated, last_out.slot1.allocated});
        check_value("r0 new_preg", 0, {last_out.slot0.new_preg, last_out.slot1.new_preg});
        check_value("r0 pops", pops_before, pop_count);
    endtask

    task automatic test_back_pressure();
        logic taken;
        int   sent;
        test_name = "back_pressure";
        @(posedge cpu_clock);
        busy <= 1'b1;
        taken = 1'b1;
        sent = 0;
        while (taken) begin
            offer_bundle(random_bundle(), taken);
            if (taken) begin
                sent++;
            end
            if (sent > 8) begin
                fail_run("rn_busy_o never rose under back-pressure");
            end
        end
        stop_input();
        repeat (3) begin
            @(negedge cpu_clock);
            check_value("out_valid held", 1, out_valid);
            check_value("held packet", exp_q[0], out_bundle);
            check_value("fl_rd under busy", 0, fl_rd);
        end
        @(posedge cpu_clock);
        busy <= 1'b0;
        wait_drain();
    endtask

    task automatic test_free_list_empty();
        rn_bundle_t b;
        test_name = "free_list_empty";
        @(posedge cpu_clock);
        fl_empty <= 2'b11;
        b.slot0 = make_slot(random_reg(), random_reg(), arch_reg_t'($urandom_range(1, 31)), 1'b1);
        b.slot1 = make_slot(random_reg(), random_reg(), arch_reg_t'($urandom_range(1, 31)), 1'b1);
        send_bundle(b);
        stop_input();
        repeat (5) begin
            @(negedge cpu_clock);
            check_value("out_valid while empty", 0, out_valid);
            check_value("fl_rd while empty", 0, fl_rd);
        end
        @(posedge cpu_clock);
        fl_empty <= 2'b00;
        wait_drain();
    endtask

    task automatic test_commit_flush();
        rn_bundle_t b;
        arch_reg_t  a0;
        arch_reg_t  a1;
        phys_reg_t  p0;
        phys_reg_t  p1;
        test_name = "commit_flush";
        a0 = arch_reg_t'($urandom_range(1, 31));
        a1 = arch_reg_t'(a0 % 31 + 1);
        p0 = phys_reg_t'($urandom_range(0, 63));
        p1 = phys_reg_t'($urandom_range(0, 63));
        @(posedge cpu_clock);
        commit[0] <= '{valid: 1'b1, arch: a0, phys: p0};
        commit[1] <= '{valid: 1'b1, arch: a1, phys: p1};
        commit_map[a0] = p0;
        commit_map[a1] = p1;
        @(posedge cpu_clock);
        commit[0] <= '0;
        commit[1] <= '0;
        // Speculative renames that the flush throws away.
        repeat (2) begin
            send_bundle(random_bundle());
        end
        stop_input();
        wait_drain();
        @(posedge cpu_clock);
        busy <= 1'b1;
        send_bundle(random_bundle());
        stop_input();
        wait_out_valid();
        @(posedge cpu_clock);
        flush <= 1'b1;
        @(posedge cpu_clock);
        flush <= 1'b0;
        busy  <= 1'b0;
        foreach (spec_map[i]) begin
            spec_map[i] = commit_map[i];
        end
        exp_q.delete();
        @(negedge cpu_clock);
        check_value("out_valid after flush", 0, out_valid);
        b.slot0 = make_slot(a0, a1, random_reg(), 1'b1);
        b.slot1 = make_slot(a1, a0, random_reg(), 1'b1);
        send_bundle(b);
        stop_input();
        wait_drain();
        check_value("committed prs1", p0, last_out.slot0.prs1);
        check_value("committed prs2", p1, last_out.slot0.prs2);
    endtask

    initial begin
        void'($urandom(32'haeea_9b43));
        rst_n     = 1'b0;
        flush     = 1'b0;
        valid     = 1'b0;
        bundle    = '0;
        busy      = 1'b0;
        fl_empty  = '0;
        fl_cnt    = '0;
        commit[0] = '0;
        commit[1] = '0;
        fl_step   = '0;
        pop_count = 0;
        exp_pops  = 0;
        model_cnt = '0;
        test_name = "reset";
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            spec_map[i]   = phys_reg_t'(i);
            commit_map[i] = phys_reg_t'(i);
        end
        repeat (10) @(posedge cpu_clock);
        rst_n <= 1'b1;
        test_first_bundle();
        test_bundle_bypass();
        test_back_pressure();
        test_free_list_empty();
        test_commit_flush();
        $display("Everything OK");
        $finish;
    end

endmodule

// File: design/rename_top.sv
`include "rename_params.svh"

module rename_top (
    input  wire logic                       cpu_clock_i,
    input  wire logic                       rst_n_i,
    input  wire logic                       flush_i,
    input  wire logic                       valid_i,
    input  wire rename_pkg::rn_bundle_t     bundle_i,
    output logic                            rn_busy_o,
    output logic                            out_valid_o,
    output rename_pkg::renamed_bundle_t     out_bundle_o,
    input  wire logic                       busy_i,
    output logic [`RN_WIDTH-1:0]            fl_rd_o,
    input  wire rename_pkg::phys_reg_t      fl_data_i [`RN_WIDTH],
    input  wire logic [`RN_WIDTH-1:0]       fl_empty_i,
    input  wire rename_pkg::commit_t        commit_i [`RN_WIDTH]
);
    import rename_pkg::*;

    logic            head_valid;
    rn_bundle_t      head_bundle;
    logic            fire;
    logic            out_ready;
    logic            ren_valid;
    renamed_bundle_t ren_bundle;

    rn_skid_buffer u_skid (
        .cpu_clock_i   (cpu_clock_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .valid_i       (valid_i),
        .bundle_i      (bundle_i),
        .rn_busy_o     (rn_busy_o),
        .pop_i         (fire),
        .head_valid_o  (head_valid),
        .head_bundle_o (head_bundle)
    );

    rn_rename_stage u_rename (
        .cpu_clock_i   (cpu_clock_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .head_valid_i  (head_valid),
        .head_bundle_i (head_bundle),
        .pop_o         (fire),
        .out_ready_i   (out_ready),
        .ren_valid_o   (ren_valid),
        .ren_bundle_o  (ren_bundle),
        .fl_rd_o       (fl_rd_o),
        .fl_data_i     (fl_data_i),
        .fl_empty_i    (fl_empty_i),
        .commit_i      (commit_i)
    );

    rn_output_reg u_out (
        .cpu_clock_i  (cpu_clock_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .ren_valid_i  (ren_valid),
        .ren_bundle_i (ren_bundle),
        .out_ready_o  (out_ready),
        .busy_i       (busy_i),
        .out_valid_o  (out_valid_o),
        .out_bundle_o (out_bundle_o)
    );

endmodule

// File: design/rn_output_reg.sv
module rn_output_reg (
    input  wire logic                        cpu_clock_i,
    input  wire logic                        rst_n_i,
    input  wire logic                        flush_i,
    input  wire logic                        ren_valid_i,
    input  wire rename_pkg::renamed_bundle_t ren_bundle_i,
    output logic                             out_ready_o,
    input  wire logic                        busy_i,
    output logic                             out_valid_o,
    output rename_pkg::renamed_bundle_t      out_bundle_o
);
    import rename_pkg::*;

    renamed_bundle_t bundle_q;
    logic            valid_q;
    logic            load;

    // Space when empty or when the retire side takes the current packet.
    assign out_ready_o = ~valid_q | ~busy_i;
    assign load        = ren_valid_i & out_ready_o;

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (out_ready_o) begin
            valid_q <= ren_valid_i;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (load) begin
            bundle_q <= ren_bundle_i;
        end
    end

    assign out_valid_o  = valid_q;
    assign out_bundle_o = bundle_q;

endmodule

// File: design/rn_rename_stage.sv
`include "rename_params.svh"

module rn_rename_stage (
    input  wire logic                       cpu_clock_i,
    input  wire logic                       rst_n_i,
    input  wire logic                       flush_i,
    input  wire logic                       head_valid_i,
    input  wire rename_pkg::rn_bundle_t     head_bundle_i,
    output logic                            pop_o,
    input  wire logic                       out_ready_i,
    output logic                            ren_valid_o,
    output rename_pkg::renamed_bundle_t     ren_bundle_o,
    output logic [`RN_WIDTH-1:0]            fl_rd_o,
    input  wire rename_pkg::phys_reg_t      fl_data_i [`RN_WIDTH],
    input  wire logic [`RN_WIDTH-1:0]       fl_empty_i,
    input  wire rename_pkg::commit_t        commit_i [`RN_WIDTH]
);
    import rename_pkg::*;

    rn_slot_t             s0;
    rn_slot_t             s1;
    arch_reg_t            rd_arch [3*`RN_WIDTH];
    phys_reg_t            rd_phys [3*`RN_WIDTH];
    logic [`RN_WIDTH-1:0] alloc;
    logic [`RN_WIDTH-1:0] wr_en;
    arch_reg_t            wr_arch [`RN_WIDTH];
    phys_reg_t            new_preg [`RN_WIDTH];
    logic                 fire;

    assign s0 = head_bundle_i.slot0;
    assign s1 = head_bundle_i.slot1;

    // Read ports: sources of both slots, then the old dests.
    assign rd_arch[0] = s0.rs1;
    assign rd_arch[1] = s0.rs2;
    assign rd_arch[2] = s1.rs1;
    assign rd_arch[3] = s1.rs2;
    assign rd_arch[4] = s0.dest;
    assign rd_arch[5] = s1.dest;

    // r0 is hardwired, it never takes a register.
    assign alloc[0] = s0.valid & s0.writes_dest & (s0.dest != '0);
    assign alloc[1] = s1.valid & s1.writes_dest & (s1.dest != '0);

    assign fire = head_valid_i & ~flush_i & out_ready_i & ~|(alloc & fl_empty_i);

    assign pop_o       = fire;
    assign ren_valid_o = fire;
    assign fl_rd_o     = {`RN_WIDTH{fire}} & alloc;
    assign wr_en       = {`RN_WIDTH{fire}} & alloc;
    assign wr_arch[0]  = s0.dest;
    assign wr_arch[1]  = s1.dest;

    always_comb begin
        for (int p = 0; p < `RN_WIDTH; p++) begin
            new_preg[p] = alloc[p] ? fl_data_i[p] : '0;
        end
    end

    always_comb begin
        ren_bundle_o.slot0.valid     = s0.valid;
        ren_bundle_o.slot0.port      = s0.port;
        ren_bundle_o.slot0.prs1      = rd_phys[0];
        ren_bundle_o.slot0.prs2      = rd_phys[1];
        ren_bundle_o.slot0.arch_dest = s0.dest;
        ren_bundle_o.slot0.allocated = alloc[0];
        ren_bundle_o.slot0.old_preg  = rd_phys[4];
        ren_bundle_o.slot0.new_preg  = new_preg[0];

        // Slot1 sees slot0's write before the table does.
        ren_bundle_o.slot1.valid     = s1.valid;
        ren_bundle_o.slot1.port      = s1.port;
        ren_bundle_o.slot1.prs1      = (alloc[0] && s1.rs1 == s0.dest) ? new_preg[0] : rd_phys[2];
        ren_bundle_o.slot1.prs2      = (alloc[0] && s1.rs2 == s0.dest) ? new_preg[0] : rd_phys[3];
        ren_bundle_o.slot1.arch_dest = s1.dest;
        ren_bundle_o.slot1.allocated = alloc[1];
        ren_bundle_o.slot1.old_preg  = (alloc[0] && s1.dest == s0.dest) ? new_preg[0] : rd_phys[5];
        ren_bundle_o.slot1.new_preg  = new_preg[1];
    end

    rn_map_table u_map (
        .cpu_clock_i (cpu_clock_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .rd_arch_i   (rd_arch),
        .rd_phys_o   (rd_phys),
        .wr_en_i     (wr_en),
        .wr_arch_i   (wr_arch),
        .wr_phys_i   (fl_data_i),
        .commit_i    (commit_i)
    );

endmodule

// File: design/rn_map_table.sv
`include "rename_params.svh"

module rn_map_table (
    input  wire logic                   cpu_clock_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   flush_i,
    input  wire rename_pkg::arch_reg_t  rd_arch_i [3*`RN_WIDTH],
    output rename_pkg::phys_reg_t       rd_phys_o [3*`RN_WIDTH],
    input  wire logic [`RN_WIDTH-1:0]   wr_en_i,
    input  wire rename_pkg::arch_reg_t  wr_arch_i [`RN_WIDTH],
    input  wire rename_pkg::phys_reg_t  wr_phys_i [`RN_WIDTH],
    input  wire rename_pkg::commit_t    commit_i [`RN_WIDTH]
);
    import rename_pkg::*;

    phys_reg_t spec_q      [`RN_ARCH_REGS];
    phys_reg_t commit_q    [`RN_ARCH_REGS];
    phys_reg_t commit_next [`RN_ARCH_REGS];

    // Committed state after this edge's commits, later port wins.
    always_comb begin
        commit_next = commit_q;
        for (int p = 0; p < `RN_WIDTH; p++) begin
            if (commit_i[p].valid) begin
                commit_next[commit_i[p].arch] = commit_i[p].phys;
            end
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                commit_q[i] <= phys_reg_t'(i);
            end
        end else begin
            commit_q <= commit_next;
        end
    end

    // Speculative table, restored from the committed one on flush.
    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                spec_q[i] <= phys_reg_t'(i);
            end
        end else if (flush_i) begin
            spec_q <= commit_next;
        end else begin
            // Slot1 is written last so it wins on a shared dest.
            for (int p = 0; p < `RN_WIDTH; p++) begin
                if (wr_en_i[p]) begin
                    spec_q[wr_arch_i[p]] <= wr_phys_i[p];
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < 3*`RN_WIDTH; k++) begin
            rd_phys_o[k] = spec_q[rd_arch_i[k]];
        end
    end

endmodule

// File: design/rn_skid_buffer.sv
module rn_skid_buffer (
    input  wire logic                   cpu_clock_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   flush_i,
    input  wire logic                   valid_i,
    input  wire rename_pkg::rn_bundle_t bundle_i,
    output logic                        rn_busy_o,
    input  wire logic                   pop_i,
    output logic                        head_valid_o,
    output rename_pkg::rn_bundle_t      head_bundle_o
);
    import rename_pkg::*;

    rn_bundle_t main_q;
    rn_bundle_t spare_q;
    logic       main_valid_q;
    logic       spare_valid_q;
    logic       busy_q;
    logic       push;
    logic       pop;
    logic       main_valid_d;
    logic       spare_valid_d;
    logic       main_load;
    logic       main_from_spare;
    logic       spare_load;

    assign push = valid_i & ~busy_q;
    assign pop  = pop_i & main_valid_q;

    always_comb begin
        main_valid_d    = main_valid_q;
        spare_valid_d   = spare_valid_q;
        main_load       = 1'b0;
        main_from_spare = 1'b0;
        spare_load      = 1'b0;
        if (pop && spare_valid_q) begin
            // Spare moves up, a new bundle may refill it.
            main_load       = 1'b1;
            main_from_spare = 1'b1;
            spare_valid_d   = push;
            spare_load      = push;
        end else if (pop || !main_valid_q) begin
            main_valid_d = push;
            main_load    = push;
        end else begin
            spare_valid_d = spare_valid_q | push;
            spare_load    = push & ~spare_valid_q;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (!rst_n_i || flush_i) begin
            main_valid_q  <= 1'b0;
            spare_valid_q <= 1'b0;
            busy_q        <= 1'b0;
        end else begin
            main_valid_q  <= main_valid_d;
            spare_valid_q <= spare_valid_d;
            busy_q        <= main_valid_d & spare_valid_d;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (main_load) begin
            main_q <= main_from_spare ? spare_q : bundle_i;
        end
        if (spare_load) begin
            spare_q <= bundle_i;
        end
    end

    assign rn_busy_o     = busy_q;
    assign head_valid_o  = main_valid_q;
    assign head_bundle_o = main_q;

endmodule

// File: design/rename_pkg.sv
`include "rename_params.svh"

package rename_pkg;

    typedef logic [`RN_ARCH_W-1:0] arch_reg_t;
    typedef logic [`RN_PHYS_W-1:0] phys_reg_t;

    // Issue port class, carried through to the output.
    typedef enum logic {
        PORT_ALU = 1'b0,
        PORT_MEM = 1'b1
    } rn_port_e;

    typedef struct packed {
        logic      valid;
        rn_port_e  port;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t dest;
        logic      writes_dest;
    } rn_slot_t;

    // Slot0 is always valid in a valid bundle.
    typedef struct packed {
        rn_slot_t slot0;
        rn_slot_t slot1;
    } rn_bundle_t;

    typedef struct packed {
        logic      valid;
        rn_port_e  port;
        phys_reg_t prs1;
        phys_reg_t prs2;
        arch_reg_t arch_dest;
        logic      allocated;
        phys_reg_t old_preg;
        phys_reg_t new_preg;
    } renamed_slot_t;

    typedef struct packed {
        renamed_slot_t slot0;
        renamed_slot_t slot1;
    } renamed_bundle_t;

    typedef struct packed {
        logic      valid;
        arch_reg_t arch;
        phys_reg_t phys;
    } commit_t;

endpackage

// File: design/rename_params.svh
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Architectural register file seen by the ISA.
`define RN_ARCH_REGS 32

// Physical register file behind the rename tables.
`define RN_PHYS_REGS 64

// Index widths follow the register counts.
`define RN_ARCH_W ($clog2(`RN_ARCH_REGS))
`define RN_PHYS_W ($clog2(`RN_PHYS_REGS))

// Instructions per bundle, also the number of free-list and commit ports.
`define RN_WIDTH 2

`endif
